// ==== all.f ====
src/rtcPkg.sv
src/busCycleEngine.sv
src/rtcInit.sv
src/rtcPoller.sv
src/userEditor.sv
src/timeShadowRegs.sv
src/mainSequencer.sv
src/rtcController.sv
tb/rtcChipModel.sv
tb/rtcControllerTb.sv

// ==== src/busCycleEngine.sv ====
`timescale 1ns/1ns
`default_nettype none

module busCycleEngine (
	input wire clk,
	input wire reset,
	input wire start,
	input wire rtcPkg::busRequestT request,
	output logic done,
	output rtcPkg::byteT readData,
	inout wire rtcPkg::byteT rtcBus,
	output logic cs,
	output logic as,
	output logic rd,
	output logic wr
);

	rtcPkg::busStateT state;
	rtcPkg::phaseCntT phaseCnt;
	rtcPkg::busRequestT activeReq;
	rtcPkg::byteT busOut;
	logic driveEn;
	logic lastAddr;
	logic lastStrobe;
	logic lastRecover;

	assign lastAddr = phaseCnt == rtcPkg::phaseCntT'(rtcPkg::addrPhaseCycles - 1);
	assign lastStrobe = phaseCnt == rtcPkg::phaseCntT'(rtcPkg::strobeCycles - 1);
	assign lastRecover = phaseCnt == rtcPkg::phaseCntT'(rtcPkg::recoverCycles - 1);

	// phase sequence: address, strobe, recovery
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rtcPkg::busIdle;
			phaseCnt <= '0;
		end else begin
			case (state)
				rtcPkg::busIdle: begin
					phaseCnt <= '0;
					if (start)
						state <= rtcPkg::busAddr;
				end
				rtcPkg::busAddr: begin
					if (lastAddr) begin
						state <= rtcPkg::busStrobe;
						phaseCnt <= '0;
					end else begin
						phaseCnt <= phaseCnt + 1'b1;
					end
				end
				rtcPkg::busStrobe: begin
					if (lastStrobe) begin
						state <= rtcPkg::busRecover;
						phaseCnt <= '0;
					end else begin
						phaseCnt <= phaseCnt + 1'b1;
					end
				end
				default: begin
					if (lastRecover) begin
						state <= rtcPkg::busIdle;
						phaseCnt <= '0;
					end else begin
						phaseCnt <= phaseCnt + 1'b1;
					end
				end
			endcase
		end
	end

	// request held for the whole cycle, read data taken at end of strobe
	always_ff @(posedge clk) begin
		if (state == rtcPkg::busIdle && start)
			activeReq <= request;
		if (state == rtcPkg::busStrobe && lastStrobe && !activeReq.write)
			readData <= rtcBus;
	end

	always_comb begin
		cs = 1'b1;
		as = 1'b0;
		rd = 1'b1;
		wr = 1'b1;
		driveEn = 1'b0;
		case (state)
			rtcPkg::busAddr: begin
				cs = 1'b0;
				as = 1'b1;
				driveEn = 1'b1;
			end
			rtcPkg::busStrobe: begin
				cs = 1'b0;
				if (activeReq.write) begin
					wr = 1'b0;
					driveEn = 1'b1;
				end else begin
					rd = 1'b0;
				end
			end
			default: ;
		endcase
	end

	assign done = state == rtcPkg::busRecover && lastRecover;
	assign busOut = state == rtcPkg::busAddr ? {1'b0, activeReq.addr} : activeReq.data;
	assign rtcBus = driveEn ? busOut : 'z;

endmodule

`default_nettype wire

// ==== src/mainSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module mainSequencer (
	input wire clk,
	input wire reset,
	input wire irqN,
	input wire editSwitch,
	output logic initStart,
	output logic pollStart,
	output logic editStart,
	input wire initFinished,
	input wire pollFinished,
	input wire editFinished,
	input wire rtcPkg::busRequestT initRequest,
	input wire initBusStart,
	input wire rtcPkg::busRequestT pollRequest,
	input wire pollBusStart,
	input wire rtcPkg::busRequestT editRequest,
	input wire editBusStart,
	output rtcPkg::busRequestT busRequest,
	output logic busStart,
	input wire busDone,
	output logic initDoneClient,
	output logic pollDoneClient,
	output logic editDoneClient
);

	rtcPkg::seqStateT state;
	logic booted;
	logic editPrev;
	logic pendingWb;
	logic editFall;

	assign editFall = editPrev & ~editSwitch;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rtcPkg::seqInit;
			booted <= 1'b0;
			editPrev <= 1'b0;
			pendingWb <= 1'b0;
			initStart <= 1'b0;
			pollStart <= 1'b0;
			editStart <= 1'b0;
		end else begin
			editPrev <= editSwitch;
			initStart <= 1'b0;
			pollStart <= 1'b0;
			editStart <= 1'b0;
			case (state)
				rtcPkg::seqInit: begin
					// kick init once after reset
					if (!booted) begin
						initStart <= 1'b1;
						booted <= 1'b1;
					end
					if (initFinished)
						state <= rtcPkg::seqIdle;
				end
				rtcPkg::seqIdle: begin
					// no poll while editing, it would overwrite the edits
					if (pendingWb) begin
						editStart <= 1'b1;
						pendingWb <= 1'b0;
						state <= rtcPkg::seqWriteBack;
					end else if (!irqN && !editSwitch) begin
						pollStart <= 1'b1;
						state <= rtcPkg::seqPoll;
					end
				end
				rtcPkg::seqPoll: begin
					if (pollFinished)
						state <= rtcPkg::seqIdle;
				end
				default: begin
					if (editFinished)
						state <= rtcPkg::seqIdle;
				end
			endcase
			if (editFall)
				pendingWb <= 1'b1;
		end
	end

	// bus goes to whoever owns the current phase
	always_comb begin
		busRequest = initRequest;
		busStart = 1'b0;
		case (state)
			rtcPkg::seqInit: begin
				busRequest = initRequest;
				busStart = initBusStart;
			end
			rtcPkg::seqPoll: begin
				busRequest = pollRequest;
				busStart = pollBusStart;
			end
			rtcPkg::seqWriteBack: begin
				busRequest = editRequest;
				busStart = editBusStart;
			end
			default: ;
		endcase
	end

	assign initDoneClient = busDone && state == rtcPkg::seqInit;
	assign pollDoneClient = busDone && state == rtcPkg::seqPoll;
	assign editDoneClient = busDone && state == rtcPkg::seqWriteBack;

endmodule

`default_nettype wire

// ==== src/rtcController.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtcController (
	input wire clk,
	input wire reset,
	inout wire rtcPkg::byteT rtcBus,
	output logic cs,
	output logic as,
	output logic rd,
	output logic wr,
	input wire irqN,
	input wire editSwitch,
	input wire up,
	input wire down,
	input wire left,
	input wire rtcPkg::fieldIdxT displayIdx,
	output rtcPkg::byteT displayData
);

	// shared bus
	rtcPkg::busRequestT busRequest;
	logic busStart;
	logic busDone;
	rtcPkg::byteT readData;

	// sequencer to clients
	logic initStart;
	logic pollStart;
	logic editStart;
	logic initFinished;
	logic pollFinished;
	logic editFinished;
	logic initDone;
	logic pollDone;
	logic editDone;

	// client requests
	rtcPkg::busRequestT initRequest;
	rtcPkg::busRequestT pollRequest;
	rtcPkg::busRequestT editRequest;
	logic initBusStart;
	logic pollBusStart;
	logic editBusStart;

	// shadow file ports
	logic shadowWe;
	rtcPkg::fieldIdxT shadowIdx;
	rtcPkg::byteT shadowData;
	logic editWe;
	rtcPkg::fieldIdxT editIdx;
	rtcPkg::byteT editData;
	rtcPkg::byteT editValue;

	mainSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.irqN(irqN),
		.editSwitch(editSwitch),
		.initStart(initStart),
		.pollStart(pollStart),
		.editStart(editStart),
		.initFinished(initFinished),
		.pollFinished(pollFinished),
		.editFinished(editFinished),
		.initRequest(initRequest),
		.initBusStart(initBusStart),
		.pollRequest(pollRequest),
		.pollBusStart(pollBusStart),
		.editRequest(editRequest),
		.editBusStart(editBusStart),
		.busRequest(busRequest),
		.busStart(busStart),
		.busDone(busDone),
		.initDoneClient(initDone),
		.pollDoneClient(pollDone),
		.editDoneClient(editDone)
	);

	busCycleEngine busEngine (
		.clk(clk),
		.reset(reset),
		.start(busStart),
		.request(busRequest),
		.done(busDone),
		.readData(readData),
		.rtcBus(rtcBus),
		.cs(cs),
		.as(as),
		.rd(rd),
		.wr(wr)
	);

	rtcInit init (
		.clk(clk),
		.reset(reset),
		.start(initStart),
		.busStart(initBusStart),
		.request(initRequest),
		.busDone(initDone),
		.finished(initFinished)
	);

	rtcPoller poller (
		.clk(clk),
		.reset(reset),
		.start(pollStart),
		.busStart(pollBusStart),
		.request(pollRequest),
		.busDone(pollDone),
		.readData(readData),
		.shadowWe(shadowWe),
		.shadowIdx(shadowIdx),
		.shadowData(shadowData),
		.finished(pollFinished)
	);

	userEditor editor (
		.clk(clk),
		.reset(reset),
		.editSwitch(editSwitch),
		.up(up),
		.down(down),
		.left(left),
		.start(editStart),
		.busStart(editBusStart),
		.request(editRequest),
		.busDone(editDone),
		.fieldIdx(editIdx),
		.fieldValue(editValue),
		.editWe(editWe),
		.editData(editData),
		.finished(editFinished)
	);

	timeShadowRegs shadow (
		.clk(clk),
		.reset(reset),
		.pollWe(shadowWe),
		.pollIdx(shadowIdx),
		.pollData(shadowData),
		.editWe(editWe),
		.editIdx(editIdx),
		.editData(editData),
		.editValue(editValue),
		.displayIdx(displayIdx),
		.displayData(displayData)
	);

endmodule

`default_nettype wire

// ==== src/rtcInit.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtcInit (
	input wire clk,
	input wire reset,
	input wire start,
	output logic busStart,
	output rtcPkg::busRequestT request,
	input wire busDone,
	output logic finished
);

	typedef enum logic [1:0] {
		initIdle,
		initWriteA,
		initWriteB
	} initStateT;

	initStateT state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= initIdle;
			busStart <= 1'b0;
			finished <= 1'b0;
		end else begin
			busStart <= 1'b0;
			finished <= 1'b0;
			case (state)
				initIdle: begin
					if (start) begin
						state <= initWriteA;
						busStart <= 1'b1;
					end
				end
				initWriteA: begin
					if (busDone) begin
						state <= initWriteB;
						busStart <= 1'b1;
					end
				end
				initWriteB: begin
					if (busDone) begin
						state <= initIdle;
						finished <= 1'b1;
					end
				end
				default: state <= initIdle;
			endcase
		end
	end

	// A first, then B
	always_comb begin
		request.write = 1'b1;
		if (state == initWriteB) begin
			request.addr = rtcPkg::regB;
			request.data = rtcPkg::regBInit;
		end else begin
			request.addr = rtcPkg::regA;
			request.data = rtcPkg::regAInit;
		end
	end

endmodule

`default_nettype wire

// ==== src/rtcPkg.sv ====
`default_nettype none

package rtcPkg;

	typedef logic [7:0] byteT;
	typedef logic [6:0] chipAddrT;
	typedef logic [2:0] fieldIdxT;

	// counts cycles inside one bus phase
	typedef logic [1:0] phaseCntT;

	// one chip bus cycle
	typedef struct packed {
		chipAddrT addr;
		byteT data;
		logic write;
	} busRequestT;

	localparam int numFields = 6;
	localparam fieldIdxT lastField = fieldIdxT'(numFields - 1);

	// seconds, minutes, hours, date, month, year
	localparam chipAddrT fieldAddr [numFields] = '{7'h00, 7'h02, 7'h04, 7'h07, 7'h08, 7'h09};
	localparam byteT fieldMax [numFields] = '{8'd59, 8'd59, 8'd23, 8'd31, 8'd12, 8'd99};
	localparam byteT fieldMin [numFields] = '{8'd0, 8'd0, 8'd0, 8'd1, 8'd1, 8'd0};

	// control registers
	localparam chipAddrT regA = 7'h0A;
	localparam chipAddrT regB = 7'h0B;
	localparam chipAddrT regC = 7'h0C;

	// oscillator on
	localparam byteT regAInit = 8'h20;
	// binary, 24h, update-ended irq enabled
	localparam byteT regBInit = 8'h16;

	localparam int addrPhaseCycles = 2;
	localparam int strobeCycles = 3;
	localparam int recoverCycles = 1;

	typedef enum logic [1:0] {
		seqInit,
		seqIdle,
		seqPoll,
		seqWriteBack
	} seqStateT;

	typedef enum logic [1:0] {
		busIdle,
		busAddr,
		busStrobe,
		busRecover
	} busStateT;

endpackage

`default_nettype wire

// ==== src/rtcPoller.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtcPoller (
	input wire clk,
	input wire reset,
	input wire start,
	output logic busStart,
	output rtcPkg::busRequestT request,
	input wire busDone,
	input wire rtcPkg::byteT readData,
	output logic shadowWe,
	output rtcPkg::fieldIdxT shadowIdx,
	output rtcPkg::byteT shadowData,
	output logic finished
);

	typedef enum logic {
		pollIdle,
		pollRead
	} pollStateT;

	pollStateT state;
	// 0 reads register C, 1 to 6 the time fields
	logic [2:0] readIdx;
	rtcPkg::fieldIdxT fieldSel;

	assign fieldSel = readIdx - 3'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pollIdle;
			readIdx <= '0;
			busStart <= 1'b0;
			shadowWe <= 1'b0;
			finished <= 1'b0;
		end else begin
			busStart <= 1'b0;
			shadowWe <= 1'b0;
			finished <= 1'b0;
			case (state)
				pollIdle: begin
					if (start) begin
						state <= pollRead;
						readIdx <= '0;
						busStart <= 1'b1;
					end
				end
				default: begin
					if (busDone) begin
						// value of C is dropped
						shadowWe <= readIdx != 3'd0;
						if (readIdx == 3'(rtcPkg::numFields)) begin
							state <= pollIdle;
							finished <= 1'b1;
						end else begin
							readIdx <= readIdx + 3'd1;
							busStart <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == pollRead && busDone) begin
			shadowIdx <= fieldSel;
			shadowData <= readData;
		end
	end

	always_comb begin
		request.write = 1'b0;
		request.data = '0;
		request.addr = readIdx == 3'd0 ? rtcPkg::regC : rtcPkg::fieldAddr[fieldSel];
	end

endmodule

`default_nettype wire

// ==== src/timeShadowRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module timeShadowRegs (
	input wire clk,
	input wire reset,
	input wire pollWe,
	input wire rtcPkg::fieldIdxT pollIdx,
	input wire rtcPkg::byteT pollData,
	input wire editWe,
	input wire rtcPkg::fieldIdxT editIdx,
	input wire rtcPkg::byteT editData,
	output rtcPkg::byteT editValue,
	input wire rtcPkg::fieldIdxT displayIdx,
	output rtcPkg::byteT displayData
);

	rtcPkg::byteT fields [rtcPkg::numFields];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < rtcPkg::numFields; i++)
				fields[i] <= rtcPkg::fieldMin[i];
		end else if (pollWe) begin
			fields[pollIdx] <= pollData;
		end else if (editWe) begin
			fields[editIdx] <= editData;
		end
	end

	// editor pointer never leaves 0..5
	assign editValue = fields[editIdx];

	// out-of-range display index reads zero
	assign displayData = displayIdx < 3'(rtcPkg::numFields) ? fields[displayIdx] : '0;

endmodule

`default_nettype wire

// ==== src/userEditor.sv ====
`timescale 1ns/1ns
`default_nettype none

module userEditor (
	input wire clk,
	input wire reset,
	input wire editSwitch,
	input wire up,
	input wire down,
	input wire left,
	input wire start,
	output logic busStart,
	output rtcPkg::busRequestT request,
	input wire busDone,
	output rtcPkg::fieldIdxT fieldIdx,
	input wire rtcPkg::byteT fieldValue,
	output logic editWe,
	output rtcPkg::byteT editData,
	output logic finished
);

	typedef enum logic {
		editIdle,
		editWriteBack
	} editStateT;

	editStateT state;
	rtcPkg::fieldIdxT pointer;
	rtcPkg::byteT maxValue;
	rtcPkg::byteT minValue;
	logic upPrev;
	logic downPrev;
	logic leftPrev;
	logic upRise;
	logic downRise;
	logic leftRise;
	logic editing;

	assign upRise = up & ~upPrev;
	assign downRise = down & ~downPrev;
	assign leftRise = left & ~leftPrev;

	// keys only count while the switch is on and no write-back runs
	assign editing = editSwitch && state == editIdle;

	assign fieldIdx = pointer;
	assign maxValue = rtcPkg::fieldMax[pointer];
	assign minValue = rtcPkg::fieldMin[pointer];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= editIdle;
			pointer <= '0;
			upPrev <= 1'b0;
			downPrev <= 1'b0;
			leftPrev <= 1'b0;
			busStart <= 1'b0;
			finished <= 1'b0;
		end else begin
			upPrev <= up;
			downPrev <= down;
			leftPrev <= left;
			busStart <= 1'b0;
			finished <= 1'b0;
			case (state)
				editIdle: begin
					if (start) begin
						state <= editWriteBack;
						pointer <= '0;
						busStart <= 1'b1;
					end else if (editing && leftRise) begin
						pointer <= pointer == rtcPkg::lastField ? '0 : pointer + 3'd1;
					end
				end
				default: begin
					if (busDone) begin
						// pointer ends back on seconds
						if (pointer == rtcPkg::lastField) begin
							state <= editIdle;
							pointer <= '0;
							finished <= 1'b1;
						end else begin
							pointer <= pointer + 3'd1;
							busStart <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	// up wins if both keys rise together
	always_comb begin
		editWe = editing && (upRise || downRise);
		if (upRise)
			editData = fieldValue >= maxValue ? minValue : fieldValue + 8'd1;
		else
			editData = fieldValue <= minValue ? maxValue : fieldValue - 8'd1;
	end

	assign request = '{addr: rtcPkg::fieldAddr[pointer], data: fieldValue, write: 1'b1};

endmodule

`default_nettype wire

// ==== tb/rtcChipModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtcChipModel (
	input wire clk,
	inout wire rtcPkg::byteT rtcBus,
	input wire cs,
	input wire as,
	input wire rd,
	input wire wr,
	output logic irqN,
	input wire irqRequest,
	input wire loadEn,
	input wire rtcPkg::chipAddrT loadAddr,
	input wire rtcPkg::byteT loadData,
	output int readCount,
	output int writeCount,
	output int protocolErrors
);

	rtcPkg::byteT regs [128];
	rtcPkg::chipAddrT addrLatch;
	rtcPkg::chipAddrT curAddr;
	rtcPkg::byteT wrData;
	int addrCnt = 0;
	int strobeCnt = 0;
	logic sawRd = 1'b0;
	logic sawWr = 1'b0;

	initial begin
		// power-up contents follow the address
		for (int i = 0; i < 128; i++)
			regs[i] = rtcPkg::byteT'(i) ^ 8'hA5;
		irqN = 1'b1;
		readCount = 0;
		writeCount = 0;
		protocolErrors = 0;
	end

	// chip drives read data while selected and rd is low
	assign rtcBus = (!cs && !rd) ? regs[curAddr] : 'z;

	// address decoded when as falls
	always @(negedge as)
		curAddr <= addrLatch;

	always @(posedge wr or posedge loadEn) begin
		if (loadEn) begin
			regs[loadAddr] <= loadData;
		end else if (sawWr) begin
			regs[curAddr] <= wrData;
			writeCount <= writeCount + 1;
		end
	end

	// phase length bookkeeping, sampled on the clock
	always @(posedge clk) begin
		if (irqRequest)
			irqN <= 1'b0;
		if (as) begin
			addrCnt <= addrCnt + 1;
			addrLatch <= rtcBus[6:0];
		end else if (addrCnt != 0) begin
			assert (addrCnt == rtcPkg::addrPhaseCycles) else begin
				protocolErrors = protocolErrors + 1;
				$display("Address phase at %0t ns lasted %0d cycles instead of %0d",
					$time, addrCnt, rtcPkg::addrPhaseCycles);
			end
			addrCnt <= 0;
		end
		assert (rd || wr) else begin
			protocolErrors = protocolErrors + 1;
			$display("Read and write strobes were both active at %0t ns", $time);
		end
		if (!rd || !wr) begin
			strobeCnt <= strobeCnt + 1;
			if (!rd)
				sawRd <= 1'b1;
			if (!wr) begin
				sawWr <= 1'b1;
				wrData <= rtcBus;
			end
		end else if (strobeCnt != 0) begin
			assert (strobeCnt == rtcPkg::strobeCycles) else begin
				protocolErrors = protocolErrors + 1;
				$display("Strobe phase at %0t ns lasted %0d cycles instead of %0d",
					$time, strobeCnt, rtcPkg::strobeCycles);
			end
			assert (sawRd != sawWr) else begin
				protocolErrors = protocolErrors + 1;
				$display("Bus cycle at %0t ns did not use exactly one of rd and wr", $time);
			end
			if (sawRd) begin
				readCount <= readCount + 1;
				// reading C acknowledges the interrupt
				if (curAddr == rtcPkg::regC)
					irqN <= 1'b1;
			end
			sawRd <= 1'b0;
			sawWr <= 1'b0;
			strobeCnt <= 0;
		end
	end

endmodule

`default_nettype wire

// ==== tb/rtcControllerTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rtcControllerTb;

	localparam int numKeys = 32;
	localparam int waitLimit = 2000;
	localparam int keyUp = 0;
	localparam int keyDown = 1;
	localparam int keyLeft = 2;

	typedef rtcPkg::byteT [rtcPkg::numFields-1:0] fieldsT;

	logic clk;
	logic reset;
	wire rtcPkg::byteT rtcBus;
	wire cs;
	wire as;
	wire rd;
	wire wr;
	wire irqN;
	logic editSwitch;
	logic up;
	logic down;
	logic left;
	rtcPkg::fieldIdxT displayIdx;
	rtcPkg::byteT displayData;

	logic irqRequest;
	logic loadEn;
	rtcPkg::chipAddrT loadAddr;
	rtcPkg::byteT loadData;
	int readCount;
	int writeCount;
	int protocolErrors;

	int displayErrors = 0;
	int checkErrors = 0;
	logic compareEn;
	fieldsT expected;
	fieldsT startFields;
	fieldsT finalFields;
	int keySeq [numKeys];
	int readBase;
	int writeBase;

	rtcController uut (
		.clk(clk),
		.reset(reset),
		.rtcBus(rtcBus),
		.cs(cs),
		.as(as),
		.rd(rd),
		.wr(wr),
		.irqN(irqN),
		.editSwitch(editSwitch),
		.up(up),
		.down(down),
		.left(left),
		.displayIdx(displayIdx),
		.displayData(displayData)
	);

	rtcChipModel chip (
		.clk(clk),
		.rtcBus(rtcBus),
		.cs(cs),
		.as(as),
		.rd(rd),
		.wr(wr),
		.irqN(irqN),
		.irqRequest(irqRequest),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.readCount(readCount),
		.writeCount(writeCount),
		.protocolErrors(protocolErrors)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// expected fields after the first count keys, editor pointer starts on seconds
	function automatic fieldsT applyKeys(input fieldsT startVal, input int count);
		fieldsT v;
		int ptr;
		v = startVal;
		ptr = 0;
		for (int k = 0; k < count; k++) begin
			if (keySeq[k] == keyUp)
				v[ptr] = v[ptr] >= rtcPkg::fieldMax[ptr] ? rtcPkg::fieldMin[ptr] : v[ptr] + 8'd1;
			else if (keySeq[k] == keyDown)
				v[ptr] = v[ptr] <= rtcPkg::fieldMin[ptr] ? rtcPkg::fieldMax[ptr] : v[ptr] - 8'd1;
			else if (keySeq[k] == keyLeft)
				ptr = ptr == rtcPkg::numFields - 1 ? 0 : ptr + 1;
		end
		return v;
	endfunction

	// biased toward the limits so that wraparound shows up
	function automatic rtcPkg::byteT randomField(input int idx);
		int pick;
		int span;
		pick = $urandom % 3;
		span = rtcPkg::fieldMax[idx] - rtcPkg::fieldMin[idx] + 1;
		if (pick == 0)
			return rtcPkg::fieldMin[idx];
		if (pick == 1)
			return rtcPkg::fieldMax[idx];
		return rtcPkg::byteT'(rtcPkg::fieldMin[idx] + $urandom % span);
	endfunction

	always @(negedge clk) begin
		if (compareEn) begin
			assert (displayData == expected[displayIdx]) else begin
				displayErrors++;
				$display("Fail at %0t ns: displayData for field %0d is %0d, expected %0d",
					$time, displayIdx, displayData, expected[displayIdx]);
			end
		end
	end

	task automatic printCounts();
		$display("display errors: %0d, check errors: %0d, protocol errors: %0d",
			displayErrors, checkErrors, protocolErrors);
	endtask

	task automatic abortOnTimeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		printCounts();
		$display("Simulation failed");
		$finish;
	endtask

	task automatic settle(input int cycles);
		repeat (cycles) @(posedge clk);
	endtask

	task automatic waitReads(input int target);
		int n;
		n = 0;
		while (readCount < target && n < waitLimit) begin
			@(posedge clk);
			n++;
		end
		if (readCount < target)
			abortOnTimeout("the chip reads of a poll");
	endtask

	task automatic waitWrites(input int target);
		int n;
		n = 0;
		while (writeCount < target && n < waitLimit) begin
			@(posedge clk);
			n++;
		end
		if (writeCount < target)
			abortOnTimeout("the chip writes");
	endtask

	task automatic waitWriteStrobe();
		int n;
		n = 0;
		while (wr !== 1'b0 && n < waitLimit) begin
			@(posedge clk);
			n++;
		end
		if (wr !== 1'b0)
			abortOnTimeout("the write-back to start");
	endtask

	task automatic waitIrqReleased();
		int n;
		n = 0;
		while (irqN !== 1'b1 && n < waitLimit) begin
			@(posedge clk);
			n++;
		end
		if (irqN !== 1'b1)
			abortOnTimeout("the interrupt to be released");
	endtask

	// returns once the chip holds irqN low
	task automatic raiseIrq();
		int n;
		n = 0;
		@(posedge clk);
		irqRequest <= 1'b1;
		@(posedge clk);
		irqRequest <= 1'b0;
		while (irqN !== 1'b0 && n < waitLimit) begin
			@(posedge clk);
			n++;
		end
		if (irqN !== 1'b0)
			abortOnTimeout("the interrupt to be asserted");
	endtask

	task automatic loadFields(input fieldsT v);
		for (int i = 0; i < rtcPkg::numFields; i++) begin
			@(posedge clk);
			loadAddr <= rtcPkg::fieldAddr[i];
			loadData <= v[i];
			@(posedge clk);
			loadEn <= 1'b1;
			@(posedge clk);
			loadEn <= 1'b0;
		end
	endtask

	task automatic pressKey(input int key);
		@(posedge clk);
		if (key == keyUp)
			up <= 1'b1;
		else if (key == keyDown)
			down <= 1'b1;
		else
			left <= 1'b1;
		@(posedge clk);
		up <= 1'b0;
		down <= 1'b0;
		left <= 1'b0;
		settle(2);
	endtask

	// one display index per cycle, checked by the compare process
	task automatic scanDisplay();
		for (int i = 0; i < rtcPkg::numFields; i++) begin
			@(posedge clk);
			displayIdx <= rtcPkg::fieldIdxT'(i);
			compareEn <= 1'b1;
		end
		@(posedge clk);
		compareEn <= 1'b0;
	endtask

	task automatic checkChipFields(input fieldsT v);
		for (int i = 0; i < rtcPkg::numFields; i++) begin
			assert (chip.regs[rtcPkg::fieldAddr[i]] == v[i]) else begin
				checkErrors++;
				$display("Fail at %0t ns: chip field %0d is %0d, expected %0d",
					$time, i, chip.regs[rtcPkg::fieldAddr[i]], v[i]);
			end
		end
	endtask

	initial begin
		void'($urandom(44));
		reset = 1'b1;
		editSwitch = 1'b0;
		up = 1'b0;
		down = 1'b0;
		left = 1'b0;
		displayIdx = '0;
		irqRequest = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		compareEn = 1'b0;
		expected = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// idle bus right after reset
		@(negedge clk);
		assert (cs === 1'b1 && as === 1'b0 && rd === 1'b1 && wr === 1'b1) else begin
			checkErrors++;
			$display("Fail at %0t ns: idle strobes are cs=%b as=%b rd=%b wr=%b",
				$time, cs, as, rd, wr);
		end
		assert (rtcBus === 8'hzz) else begin
			checkErrors++;
			$display("Fail at %0t ns: rtcBus is %h, expected high impedance", $time, rtcBus);
		end

		// control registers after init
		waitWrites(2);
		settle(2);
		assert (chip.regs[rtcPkg::regA] == rtcPkg::regAInit) else begin
			checkErrors++;
			$display("Fail at %0t ns: register A is %h", $time, chip.regs[rtcPkg::regA]);
		end
		assert (chip.regs[rtcPkg::regB] == rtcPkg::regBInit) else begin
			checkErrors++;
			$display("Fail at %0t ns: register B is %h", $time, chip.regs[rtcPkg::regB]);
		end

		// poll of random legal fields
		for (int i = 0; i < rtcPkg::numFields; i++)
			startFields[i] = randomField(i);
		loadFields(startFields);
		readBase = readCount;
		raiseIrq();
		waitIrqReleased();
		waitReads(readBase + 1 + rtcPkg::numFields);
		settle(3);
		expected = startFields;
		scanDisplay();

		// edit session
		@(posedge clk);
		editSwitch <= 1'b1;
		settle(2);
		for (int k = 0; k < numKeys; k++)
			keySeq[k] = $urandom % 3;
		for (int k = 0; k < numKeys; k++) begin
			pressKey(keySeq[k]);
			expected = applyKeys(startFields, k + 1);
			scanDisplay();
		end
		finalFields = applyKeys(startFields, numKeys);

		// write-back with an interrupt arriving in the middle
		writeBase = writeCount;
		readBase = readCount;
		@(posedge clk);
		editSwitch <= 1'b0;
		waitWriteStrobe();
		raiseIrq();
		waitIrqReleased();
		// register C is read only once the whole write-back is done
		assert (writeCount == writeBase + rtcPkg::numFields) else begin
			checkErrors++;
			$display("Fail at %0t ns: register C was read after %0d of %0d write-back cycles",
				$time, writeCount - writeBase, rtcPkg::numFields);
		end
		waitWrites(writeBase + rtcPkg::numFields);
		settle(2);
		checkChipFields(finalFields);
		waitReads(readBase + 1 + rtcPkg::numFields);
		settle(3);
		expected = finalFields;
		scanDisplay();

		printCounts();
		if (displayErrors + checkErrors + protocolErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
